//--- Makefile
# Verilator build and run for the exception unit testbench

TOP = tb_epu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/epu_params.svh
//######################################################################
// Exception unit parameters
// Widths, micro-op codes, machine-state address fields and the
// constant and reset values of the processor-state bank
//######################################################################
`ifndef EPU_PARAMS_SVH
`define EPU_PARAMS_SVH

`define EPU_DW              32
`define EPU_PSR_DW          10
`define EPU_ROB_AW          3
`define EPU_IQ_AW           2
`define EPU_UOP_W           3
`define EPU_IMM_W           15

// Micro-op codes, zero is no operation
`define EPU_UOP_ESYSCALL    3'd1
`define EPU_UOP_ERET        3'd2
`define EPU_UOP_EINSN       3'd3
`define EPU_UOP_EIRQ        3'd4
`define EPU_UOP_WMSR        3'd5
`define EPU_UOP_RMSR        3'd6

// Machine-state address fields
`define EPU_MSR_BANK_AW     5
`define EPU_MSR_OFF_AW      9
`define EPU_MSR_BANK_PS     5'd0

// One-hot offset bits inside the processor-state bank
`define EPU_OFF_PSR         0
`define EPU_OFF_CPUID       1
`define EPU_OFF_EPSR        2
`define EPU_OFF_EPC         3
`define EPU_OFF_ELSA        4
`define EPU_OFF_COREID      5

`define EPU_CPUID_VAL       32'h0032_0001
`define EPU_COREID_VAL      32'h0000_0000
// RM set, everything else clear
`define EPU_PSR_RST         10'h010

`endif

//--- common/epu_pkg.sv
//######################################################################
// Exception unit types
// Processor-state word, machine-state address, issue entry,
// write-back result and commit commands to the state bank
//######################################################################
`include "epu_params.svh"

package epu_pkg;

   // Field order as in the core PSR, rm sits at bit 4
   typedef struct packed {
      logic [1:0] res_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] res_lo;
   } psr_t;

   typedef struct packed {
      logic [`EPU_DW-`EPU_MSR_BANK_AW-`EPU_MSR_OFF_AW-1:0] unused;
      logic [`EPU_MSR_BANK_AW-1:0]                          bank;
      logic [`EPU_MSR_OFF_AW-1:0]                           off;
   } msr_addr_f_t;

   // Address word, seen raw when formed and split when decoded
   typedef union packed {
      logic [`EPU_DW-1:0] raw;
      msr_addr_f_t        f;
   } msr_addr_u;

   typedef struct packed {
      logic [`EPU_UOP_W-1:0]  uop;
      logic [`EPU_ROB_AW-1:0] id;
      logic [`EPU_DW-1:0]     op1;
      logic [`EPU_DW-1:0]     op2;
      logic [`EPU_IMM_W-1:0]  imm;
   } issue_req_t;

   typedef struct packed {
      logic [`EPU_DW-1:0]     data;
      logic [`EPU_ROB_AW-1:0] id;
      logic                   eret;
      logic                   esyscall;
      logic                   einsn;
      logic                   eirq;
   } wb_result_t;

   // Strobes are only high in the retire cycle
   typedef struct packed {
      logic                      exc_syscall;
      logic                      exc_insn;
      logic                      exc_irq;
      logic                      eret;
      logic                      wmsr_ps;
      logic [`EPU_MSR_OFF_AW-1:0] off;
      logic [`EPU_DW-1:0]        wdata;
      logic [`EPU_DW-3:0]        pc;
   } msr_cmd_t;

endpackage

//--- epu/epu_exec_stage.sv
//######################################################################
// Execute stage
// Holds one micro-op, decodes it, waits for the commit pointer and
// issues the retire-cycle commands to the processor-state bank
//######################################################################
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_exec_stage
   import epu_pkg::*;
(
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_flush,
   input  logic                   i_head_valid,
   input  issue_req_t             i_head,
   output logic                   o_pop,
   input  logic [`EPU_ROB_AW-1:0] i_rob_commit_ptr,
   input  logic [`EPU_DW-3:0]     i_rob_commit_pc,
   input  logic                   i_wb_ready,
   output logic                   o_wb_valid,
   output wb_result_t             o_wb,
   output msr_cmd_t               o_cmd,
   input  logic [`EPU_DW-1:0]     i_rdata,
   output logic                   o_exc_ent
);

   logic                         valid_q;
   issue_req_t                   req_q;
   logic                         commit;
   logic                         retire;
   logic [`EPU_UOP_RMSR:1]       uop_oh;
   msr_addr_u                    addr;
   logic                         bank_ps;
   logic                         rmsr_ps;
   logic                         wmsr_ps;
   logic                         exc;
   logic [`EPU_MSR_OFF_AW-1:0]   off;

   // Wait for the ROB to reach this id
   assign commit     = (i_rob_commit_ptr == req_q.id) & ~i_flush;
   assign o_wb_valid = valid_q & commit;
   assign retire     = o_wb_valid & i_wb_ready;

   // Refill when empty or emptying this cycle
   assign o_pop = i_head_valid & ~i_flush & (~valid_q | retire);

   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
         valid_q <= 1'b0;
      else if (o_pop)
         valid_q <= 1'b1;
      else if (retire)
         valid_q <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (o_pop)
         req_q <= i_head;
   end

   // One line per micro-op code
   for (genvar i = 1; i <= `EPU_UOP_RMSR; i++)
   begin : g_uop
      assign uop_oh[i] = (req_q.uop == `EPU_UOP_W'(i));
   end

   assign addr.raw = req_q.op1 | {{(`EPU_DW-`EPU_IMM_W){1'b0}}, req_q.imm};
   assign bank_ps  = (addr.f.bank == `EPU_MSR_BANK_PS);
   assign rmsr_ps  = uop_oh[`EPU_UOP_RMSR] & bank_ps;
   assign wmsr_ps  = uop_oh[`EPU_UOP_WMSR] & bank_ps;
   assign exc      = uop_oh[`EPU_UOP_ESYSCALL] | uop_oh[`EPU_UOP_EINSN]
                     | uop_oh[`EPU_UOP_EIRQ];

   // ERET reads EPC through the bank readout
   always_comb
   begin
      off = addr.f.off;
      if (uop_oh[`EPU_UOP_ERET])
         off = `EPU_MSR_OFF_AW'(1) << `EPU_OFF_EPC;
   end

   // Result
   always_comb
   begin
      o_wb.data     = (rmsr_ps | uop_oh[`EPU_UOP_ERET]) ? i_rdata : '0;
      o_wb.id       = req_q.id;
      o_wb.eret     = uop_oh[`EPU_UOP_ERET];
      o_wb.esyscall = uop_oh[`EPU_UOP_ESYSCALL];
      o_wb.einsn    = uop_oh[`EPU_UOP_EINSN];
      o_wb.eirq     = uop_oh[`EPU_UOP_EIRQ];
   end

   // Commit commands
   always_comb
   begin
      o_cmd.exc_syscall = retire & uop_oh[`EPU_UOP_ESYSCALL];
      o_cmd.exc_insn    = retire & uop_oh[`EPU_UOP_EINSN];
      o_cmd.exc_irq     = retire & uop_oh[`EPU_UOP_EIRQ];
      o_cmd.eret        = retire & uop_oh[`EPU_UOP_ERET];
      o_cmd.wmsr_ps     = retire & wmsr_ps;
      o_cmd.off         = off;
      o_cmd.wdata       = req_q.op2;
      o_cmd.pc          = i_rob_commit_pc;
   end

   assign o_exc_ent = retire & exc;

   // Write-back carries exactly one known micro-op, so at most one exception kind
   a_one_flag: assert property (@(posedge clk) disable iff (i_rst)
      o_wb_valid |-> $onehot(uop_oh))
      else $error("write-back of an item without exactly one known micro-op");

endmodule

//--- epu/epu_issue_queue.sv
//######################################################################
// Issue queue
// In-order FIFO of micro-ops waiting for the execute register,
// emptied in one cycle by flush
//######################################################################
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_issue_queue
   import epu_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_flush,
   input  logic       i_push_valid,
   output logic       o_push_ready,
   input  issue_req_t i_push,
   output logic       o_head_valid,
   output issue_req_t o_head,
   input  logic       i_pop
);

   localparam int AW    = `EPU_IQ_AW;
   localparam int DEPTH = 1 << AW;

   issue_req_t      mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [AW:0]     count;
   logic            push;

   // Depth is a power of two, so the top count bit means full
   assign o_push_ready = ~count[AW];
   assign o_head_valid = (count != '0);
   assign o_head       = mem[rd_ptr];

   assign push = i_push_valid & o_push_ready;

   always_ff @(posedge clk)
   begin
      if (i_rst | i_flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (i_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= i_push;
   end

   // Execute stage only pops what it saw as a valid head
   a_no_pop_empty: assert property (@(posedge clk) disable iff (i_rst)
      i_pop |-> o_head_valid)
      else $error("issue queue popped while empty");

endmodule

//--- epu/epu_ps_bank.sv
//######################################################################
// Processor-state bank
// PSR, EPSR, EPC and ELSA with exception entry, return and
// write updates, plus one-hot offset readout
//######################################################################
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_ps_bank
   import epu_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  msr_cmd_t           i_cmd,
   output logic [`EPU_DW-1:0] o_rdata,
   output psr_t               o_psr
);

   psr_t               psr_q;
   psr_t               epsr_q;
   logic [`EPU_DW-1:0] epc_q;
   logic [`EPU_DW-1:0] elsa_q;
   psr_t               wpsr;
   logic               exc;
   logic [`EPU_DW-3:0] link_pc;
   logic               we_psr;
   logic               we_epsr;
   logic               we_epc;
   logic               we_elsa;

   assign wpsr    = psr_t'(i_cmd.wdata[`EPU_PSR_DW-1:0]);
   assign exc     = i_cmd.exc_syscall | i_cmd.exc_insn | i_cmd.exc_irq;
   // Syscall returns past itself
   assign link_pc = i_cmd.pc + 1'b1;

   assign we_psr  = i_cmd.wmsr_ps & i_cmd.off[`EPU_OFF_PSR];
   assign we_epsr = i_cmd.wmsr_ps & i_cmd.off[`EPU_OFF_EPSR];
   assign we_epc  = i_cmd.wmsr_ps & i_cmd.off[`EPU_OFF_EPC];
   assign we_elsa = i_cmd.wmsr_ps & i_cmd.off[`EPU_OFF_ELSA];

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         psr_q  <= psr_t'(`EPU_PSR_RST);
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end
      else
      begin
         // Entry drops to real mode with IRQs and MMUs off
         if (exc)
         begin
            psr_q.rm   <= 1'b1;
            psr_q.ire  <= 1'b0;
            psr_q.imme <= 1'b0;
            psr_q.dmme <= 1'b0;
         end
         else if (i_cmd.eret)
         begin
            psr_q.rm   <= epsr_q.rm;
            psr_q.ire  <= epsr_q.ire;
            psr_q.imme <= epsr_q.imme;
            psr_q.dmme <= epsr_q.dmme;
         end
         else if (we_psr)
         begin
            psr_q.rm   <= wpsr.rm;
            psr_q.ire  <= wpsr.ire;
            psr_q.imme <= wpsr.imme;
            psr_q.dmme <= wpsr.dmme;
         end

         if (exc)
            epsr_q <= psr_q;
         else if (we_epsr)
            epsr_q <= wpsr;

         if (exc)
            epc_q <= i_cmd.exc_syscall ? {link_pc, 2'b00} : {i_cmd.pc, 2'b00};
         else if (we_epc)
            epc_q <= i_cmd.wdata;

         // Faulting instruction address
         if (i_cmd.exc_insn)
            elsa_q <= {i_cmd.pc, 2'b00};
         else if (we_elsa)
            elsa_q <= i_cmd.wdata;
      end
   end

   // Readout
   always_comb
   begin
      o_rdata = '0;
      if (i_cmd.off[`EPU_OFF_PSR])
         o_rdata |= {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr_q};
      if (i_cmd.off[`EPU_OFF_CPUID])
         o_rdata |= `EPU_CPUID_VAL;
      if (i_cmd.off[`EPU_OFF_EPSR])
         o_rdata |= {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, epsr_q};
      if (i_cmd.off[`EPU_OFF_EPC])
         o_rdata |= epc_q;
      if (i_cmd.off[`EPU_OFF_ELSA])
         o_rdata |= elsa_q;
      if (i_cmd.off[`EPU_OFF_COREID])
         o_rdata |= `EPU_COREID_VAL;
   end

   assign o_psr = psr_q;

   // Only one instruction retires per cycle
   a_eret_vs_wpsr: assert property (@(posedge clk) disable iff (i_rst)
      !(i_cmd.eret && we_psr))
      else $error("ERET and PSR write in the same cycle");

endmodule

//--- epu/epu_top.sv
//######################################################################
// Exception and machine-state unit
// Issue queue, execute register and processor-state bank
//######################################################################
`timescale 1ns/100ps
`include "epu_params.svh"

module epu_top
   import epu_pkg::*;
(
   input  logic                   clk,
   input  logic                   i_rst,
   input  logic                   i_flush,
   // From dispatch
   input  issue_req_t             i_issue,
   input  logic                   i_issue_valid,
   output logic                   o_issue_ready,
   // From ROB
   input  logic [`EPU_ROB_AW-1:0] i_rob_commit_ptr,
   input  logic [`EPU_DW-3:0]     i_rob_commit_pc,
   // To write-back
   input  logic                   i_wb_ready,
   output logic                   o_wb_valid,
   output wb_result_t             o_wb,
   output logic                   o_exc_ent,
   output psr_t                   o_psr
);

   logic               head_valid;
   issue_req_t         head;
   logic               pop;
   msr_cmd_t           cmd;
   logic [`EPU_DW-1:0] rdata;

   epu_issue_queue u_queue (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_flush      (i_flush),
      .i_push_valid (i_issue_valid),
      .o_push_ready (o_issue_ready),
      .i_push       (i_issue),
      .o_head_valid (head_valid),
      .o_head       (head),
      .i_pop        (pop)
   );

   epu_exec_stage u_exec (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_flush          (i_flush),
      .i_head_valid     (head_valid),
      .i_head           (head),
      .o_pop            (pop),
      .i_rob_commit_ptr (i_rob_commit_ptr),
      .i_rob_commit_pc  (i_rob_commit_pc),
      .i_wb_ready       (i_wb_ready),
      .o_wb_valid       (o_wb_valid),
      .o_wb             (o_wb),
      .o_cmd            (cmd),
      .i_rdata          (rdata),
      .o_exc_ent        (o_exc_ent)
   );

   epu_ps_bank u_ps_bank (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_cmd   (cmd),
      .o_rdata (rdata),
      .o_psr   (o_psr)
   );

endmodule

//--- files.f
+incdir+common
+incdir+test
common/epu_pkg.sv
epu/epu_issue_queue.sv
epu/epu_exec_stage.sv
epu/epu_ps_bank.sv
epu/epu_top.sv
test/tb_epu.sv

//--- test/tb_epu_table.svh
//######################################################################
// Exception unit testbench table
// Micro-op rows with operands, commit pc and expected write-back
//######################################################################
`ifndef TB_EPU_TABLE_SVH
`define TB_EPU_TABLE_SVH

// Columns: name, uop, op1, op2, imm, commit pc, data, flags, exc_ent
// Flags are {eret, esyscall, einsn, eirq}
// Offsets are one-hot: PSR 001, CPUID 002, EPSR 004, EPC 008, ELSA 010, COREID 020
task automatic load_table();
   // State after reset
   add_row("rd_psr_rst",  `EPU_UOP_RMSR,     0, 0,            'h001, 0, 'h0000_0010, 'b0000, 0);
   add_row("rd_cpuid",    `EPU_UOP_RMSR,     0, 0,            'h002, 0, 'h0032_0001, 'b0000, 0);
   add_row("rd_coreid",   `EPU_UOP_RMSR,     0, 0,            'h020, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_bank1",    `EPU_UOP_RMSR,     0, 0,            'h202, 0, 'h0000_0000, 'b0000, 0);
   // Writes followed by reads, address partly from op1
   add_row("wr_epc",      `EPU_UOP_WMSR,     0, 'h1234_5678,  'h008, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_epc",      `EPU_UOP_RMSR,     'h8, 0,          'h000, 0, 'h1234_5678, 'b0000, 0);
   add_row("wr_elsa",     `EPU_UOP_WMSR,     0, 'hCAFE_F00D,  'h010, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_elsa",     `EPU_UOP_RMSR,     0, 0,            'h010, 0, 'hCAFE_F00D, 'b0000, 0);
   add_row("wr_epsr",     `EPU_UOP_WMSR,     0, 'hFFFF_FEE5,  'h004, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_epsr",     `EPU_UOP_RMSR,     0, 0,            'h004, 0, 'h0000_02E5, 'b0000, 0);
   add_row("wr_cpuid",    `EPU_UOP_WMSR,     0, 'hDEAD_BEEF,  'h002, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_cpuid2",   `EPU_UOP_RMSR,     0, 0,            'h002, 0, 'h0032_0001, 'b0000, 0);
   // PSR keeps only dmme, imme, ire and rm
   add_row("wr_psr",      `EPU_UOP_WMSR,     0, 'h0000_03FF,  'h001, 0, 'h0000_0000, 'b0000, 0);
   add_row("rd_psr",      `EPU_UOP_RMSR,     0, 0,            'h001, 0, 'h0000_00F0, 'b0000, 0);
   // Syscall at pc 100h returns to the next word
   add_row("syscall",     `EPU_UOP_ESYSCALL, 0, 0,            'h000, 'h100, 0,       'b0100, 1);
   add_row("sys_epc",     `EPU_UOP_RMSR,     0, 0,            'h008, 0, 'h0000_0404, 'b0000, 0);
   add_row("sys_epsr",    `EPU_UOP_RMSR,     0, 0,            'h004, 0, 'h0000_00F0, 'b0000, 0);
   add_row("sys_psr",     `EPU_UOP_RMSR,     0, 0,            'h001, 0, 'h0000_0010, 'b0000, 0);
   // Illegal instruction at pc 2000h
   add_row("insn",        `EPU_UOP_EINSN,    0, 0,            'h000, 'h2000, 0,      'b0010, 1);
   add_row("insn_epc",    `EPU_UOP_RMSR,     0, 0,            'h008, 0, 'h0000_8000, 'b0000, 0);
   add_row("insn_elsa",   `EPU_UOP_RMSR,     0, 0,            'h010, 0, 'h0000_8000, 'b0000, 0);
   // Interrupt at pc ABCh leaves ELSA alone
   add_row("irq",         `EPU_UOP_EIRQ,     0, 0,            'h000, 'hABC, 0,       'b0001, 1);
   add_row("irq_epc",     `EPU_UOP_RMSR,     0, 0,            'h008, 0, 'h0000_2AF0, 'b0000, 0);
   add_row("irq_elsa",    `EPU_UOP_RMSR,     0, 0,            'h010, 0, 'h0000_8000, 'b0000, 0);
   // Return with dmme and ire set in EPSR
   add_row("wr_epsr2",    `EPU_UOP_WMSR,     0, 'h0000_00A0,  'h004, 0, 'h0000_0000, 'b0000, 0);
   add_row("eret",        `EPU_UOP_ERET,     0, 0,            'h000, 0, 'h0000_2AF0, 'b1000, 0);
   add_row("eret_psr",    `EPU_UOP_RMSR,     0, 0,            'h001, 0, 'h0000_00A0, 'b0000, 0);
endtask

`endif

//--- test/tb_epu.sv
//######################################################################
// Exception unit testbench
// Issues table rows in groups of three, steps the commit pointer
// with random delays and back-pressure, and checks every result
//######################################################################
`timescale 1ns/100ps
`include "epu_params.svh"

module tb_epu
   import epu_pkg::*;
();

   localparam int TIMEOUT = 200;

   typedef struct packed {
      logic [`EPU_UOP_W-1:0] uop;
      logic [`EPU_DW-1:0]    op1;
      logic [`EPU_DW-1:0]    op2;
      logic [`EPU_IMM_W-1:0] imm;
      logic [`EPU_DW-3:0]    pc;
      logic [`EPU_DW-1:0]    data;
      logic [3:0]            flags;
      logic                  exc;
   } row_t;

   logic                   clk;
   logic                   i_rst;
   logic                   i_flush;
   issue_req_t             i_issue;
   logic                   i_issue_valid;
   logic                   o_issue_ready;
   logic [`EPU_ROB_AW-1:0] i_rob_commit_ptr;
   logic [`EPU_DW-3:0]     i_rob_commit_pc;
   logic                   i_wb_ready;
   logic                   o_wb_valid;
   wb_result_t             o_wb;
   logic                   o_exc_ent;
   psr_t                   o_psr;

   row_t   rows [$];
   string  names [$];
   integer seed = 66923;
   logic   bp_en;

   epu_top UUT (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_flush          (i_flush),
      .i_issue          (i_issue),
      .i_issue_valid    (i_issue_valid),
      .o_issue_ready    (o_issue_ready),
      .i_rob_commit_ptr (i_rob_commit_ptr),
      .i_rob_commit_pc  (i_rob_commit_pc),
      .i_wb_ready       (i_wb_ready),
      .o_wb_valid       (o_wb_valid),
      .o_wb             (o_wb),
      .o_exc_ent        (o_exc_ent),
      .o_psr            (o_psr)
   );

   `include "tb_epu_table.svh"

   task automatic add_row(input string name, input logic [`EPU_UOP_W-1:0] uop,
                          input logic [31:0] op1, op2, imm, pc, data, flags, exc);
      row_t r;
      r.uop   = uop;
      r.op1   = op1;
      r.op2   = op2;
      r.imm   = imm[`EPU_IMM_W-1:0];
      r.pc    = pc[`EPU_DW-3:0];
      r.data  = data;
      r.flags = flags[3:0];
      r.exc   = exc[0];
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("** Error: %s expected %h actual %h", name, expected, actual);
         $display(">>> FAIL");
         $fatal(1);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   // Rising edge, with random write-back stalls once enabled
   task automatic next_cycle();
      @(posedge clk);
      if (bp_en)
         i_wb_ready <= (({$random(seed)} % 4) != 0);
      else
         i_wb_ready <= 1'b1;
   endtask

   task automatic issue_row(input int idx);
      int n;
      next_cycle();
      i_issue_valid <= 1'b1;
      i_issue       <= '{uop: rows[idx].uop, id: `EPU_ROB_AW'(idx % 8), op1: rows[idx].op1,
                         op2: rows[idx].op2, imm: rows[idx].imm};
      @(negedge clk);
      n = 0;
      // Accepted on the next edge once ready is seen high
      while (!o_issue_ready)
      begin
         n++;
         if (n > TIMEOUT)
            report_timeout($sformatf("issue queue to accept row %0d", idx));
         next_cycle();
         @(negedge clk);
      end
   endtask

   task automatic commit_row(input int idx);
      row_t r;
      int   n;
      int   delay;
      r = rows[idx];
      next_cycle();
      i_rob_commit_ptr <= `EPU_ROB_AW'(idx % 8);
      i_rob_commit_pc  <= r.pc;
      @(negedge clk);
      n = 0;
      while (!(o_wb_valid && i_wb_ready))
      begin
         check_value({names[idx], " exc_ent idle"}, 0, 32'(o_exc_ent));
         n++;
         if (n > TIMEOUT)
            report_timeout($sformatf("write-back of row %0d", idx));
         next_cycle();
         @(negedge clk);
      end
      check_value({names[idx], " id"}, 32'(idx % 8), 32'(o_wb.id));
      check_value({names[idx], " data"}, r.data, o_wb.data);
      check_value({names[idx], " flags"}, 32'(r.flags),
                  32'({o_wb.eret, o_wb.esyscall, o_wb.einsn, o_wb.eirq}));
      check_value({names[idx], " exc_ent"}, 32'(r.exc), 32'(o_exc_ent));
      // Hold the retired id before moving on
      delay = {$random(seed)} % 4;
      repeat (delay) next_cycle();
   endtask

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      int g;
      int i;
      i_rst            = 1'b1;
      i_flush          = 1'b0;
      i_issue          = '0;
      i_issue_valid    = 1'b0;
      i_rob_commit_ptr = 3'd7;
      i_rob_commit_pc  = '0;
      i_wb_ready       = 1'b1;
      bp_en            = 1'b0;
      load_table();
      repeat (16) @(posedge clk);
      i_rst <= 1'b0;
      @(negedge clk);
      check_value("reset wb_valid", 0, 32'(o_wb_valid));
      check_value("reset exc_ent", 0, 32'(o_exc_ent));
      check_value("reset issue_ready", 1, 32'(o_issue_ready));
      bp_en = 1'b1;
      for (g = 0; g < rows.size(); g += 3)
      begin
         for (i = g; i < g + 3 && i < rows.size(); i++)
            issue_row(i);
         next_cycle();
         i_issue_valid <= 1'b0;
         for (i = g; i < g + 3 && i < rows.size(); i++)
            commit_row(i);
         // Nothing left over once the group has retired
         next_cycle();
         @(negedge clk);
         check_value($sformatf("group %0d extra result", g / 3), 0, 32'(o_wb_valid));
      end
      check_value("final psr", 'h0A0, 32'(o_psr));
      $display(">>> PASS");
      $finish;
   end

endmodule
